// File: design/bpu.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module bpu
    import frontend_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  fetch_rsp_t       fetch_rsp,
    input  logic             flush,
    input  bpu_update_t      update,
    output logic             redirect,
    output logic [31:0]      redirect_pc,
    output fetch_pkt_t [1:0] push_pkt,
    output logic [1:0]       push_valid
);

    localparam int IDX_W = $clog2(`BHT_ENTRIES);

    ctr_t             bht [`BHT_ENTRIES];
    logic             squash_q;
    logic [31:0]      slot_pc [2];
    inst_word_u       slot_word [2];
    fetch_pkt_t       slot_pkt [2];
    logic             use0;
    logic             use1;
    logic             take0;
    logic             take1;
    logic [IDX_W-1:0] upd_idx;

    //////////////////////////////////////////////////////////////////////
    // Predecode of one slot
    //////////////////////////////////////////////////////////////////////

    function automatic fetch_pkt_t predecode(
        input logic [31:0] pc,
        input inst_word_u  word,
        input logic        ctr_msb
    );
        logic [31:0] offs26;
        logic [31:0] offs16;
        logic        is_uncond;
        logic        is_cond;
        fetch_pkt_t  pkt;

        offs26 = {{4{word.br26.offs_hi10[9]}}, word.br26.offs_hi10,
                  word.br26.offs_lo16, 2'b00};
        offs16 = {{14{word.br16.offs16[15]}}, word.br16.offs16, 2'b00};

        is_uncond = word.br26.opcode inside {OP_B, OP_BL};
        is_cond   = word.br16.opcode inside {OP_BEQ, OP_BNE, OP_BLT,
                                             OP_BGE, OP_BLTU, OP_BGEU};

        pkt.pc         = pc;
        pkt.inst       = word;
        pkt.pred_taken = is_uncond || (is_cond && ctr_msb);
        if (is_uncond) begin
            pkt.pred_target = pc + offs26;
        end else if (is_cond) begin
            pkt.pred_target = pc + offs16;
        end else begin
            pkt.pred_target = pc + 32'd4;
        end
        return pkt;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slot_pc[i]   = {fetch_rsp.pc[31:3], 1'(i), 2'b00};
            slot_word[i] = fetch_rsp.inst[i];
            slot_pkt[i]  = predecode(slot_pc[i], slot_word[i],
                                     bht[slot_pc[i][IDX_W+1:2]][1]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Slot selection and redirect
    //////////////////////////////////////////////////////////////////////

    // Slot 0 is skipped when the pair was fetched from its upper word
    assign use0  = fetch_rsp.valid && !squash_q && !fetch_rsp.pc[2];
    assign take0 = use0 && slot_pkt[0].pred_taken;
    assign use1  = fetch_rsp.valid && !squash_q && !take0;
    assign take1 = use1 && slot_pkt[1].pred_taken;

    assign redirect    = take0 || take1;
    assign redirect_pc = take0 ? slot_pkt[0].pred_target : slot_pkt[1].pred_target;

    // Compacted so the buffer sees valid patterns 00, 01, 11 only
    always_comb begin
        push_pkt[1] = slot_pkt[1];
        if (use0) begin
            push_pkt[0] = slot_pkt[0];
            push_valid  = {use1, 1'b1};
        end else begin
            push_pkt[0] = slot_pkt[1];
            push_valid  = {1'b0, use1};
        end
    end

    // Request issued during a redirect or flush returns stale
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            squash_q <= 1'b0;
        end else begin
            squash_q <= redirect || flush;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counter table training
    //////////////////////////////////////////////////////////////////////

    assign upd_idx = update.pc[IDX_W+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                bht[i] <= CTR_WNT;
            end
        end else if (flush) begin
            if (update.taken && bht[upd_idx] != CTR_ST) begin
                bht[upd_idx] <= bht[upd_idx] + 2'd1;
            end else if (!update.taken && bht[upd_idx] != CTR_SNT) begin
                bht[upd_idx] <= bht[upd_idx] - 2'd1;
            end
        end
    end

endmodule

// File: design/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Front end sizing
//////////////////////////////////////////////////////////////////////

// First fetch address out of reset
`define RESET_PC 32'h1c00_0000

// Instruction buffer entries, power of two, at least 4
`define IBUF_DEPTH 8

// 2-bit counters, indexed by pc bits above the word offset
`define BHT_ENTRIES 16

`endif

// File: design/frontend_pkg.sv
package frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Fetch port
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    // Aligned pair, inst[0] is the lower address
    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [1:0][31:0] inst;
    } fetch_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Instruction word views used by predecode
    //////////////////////////////////////////////////////////////////////

    // BEQ, BNE, BLT, BGE, BLTU, BGEU
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } br16_t;

    // B, BL: offset split with the high part in the low bits
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo16;
        logic [9:0]  offs_hi10;
    } br26_t;

    typedef union packed {
        br16_t br16;
        br26_t br26;
    } inst_word_u;

    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;
    localparam logic [5:0] OP_BLT  = 6'b011000;
    localparam logic [5:0] OP_BGE  = 6'b011001;
    localparam logic [5:0] OP_BLTU = 6'b011010;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    //////////////////////////////////////////////////////////////////////
    // Backend side
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pred_taken;
        logic [31:0] pred_target;
    } fetch_pkt_t;

    // Training data, sent along with flush
    typedef struct packed {
        logic [31:0] pc;
        logic        taken;
    } bpu_update_t;

    // Saturating direction counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_SNT = 2'b00;
    localparam ctr_t CTR_WNT = 2'b01;
    localparam ctr_t CTR_ST  = 2'b11;

endpackage

// File: design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top
    import frontend_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,

    // Instruction cache port
    output fetch_req_t       fetch_req,
    input  fetch_rsp_t       fetch_rsp,

    // Backend port
    input  logic             accept,
    input  logic             flush,
    input  logic [31:0]      new_pc,
    input  bpu_update_t      update,
    output fetch_pkt_t [1:0] out_pkt,
    output logic [1:0]       out_valid
);

    logic             redirect;
    logic [31:0]      redirect_pc;
    fetch_pkt_t [1:0] push_pkt;
    logic [1:0]       push_valid;
    logic             almost_full;

    pc_reg u_pc_reg (
        .clk,
        .arst_n,
        .redirect,
        .redirect_pc,
        .flush,
        .new_pc,
        .almost_full,
        .fetch_req
    );

    bpu u_bpu (
        .clk,
        .arst_n,
        .fetch_rsp,
        .flush,
        .update,
        .redirect,
        .redirect_pc,
        .push_pkt,
        .push_valid
    );

    inst_buffer u_inst_buffer (
        .clk,
        .arst_n,
        .flush,
        .push_pkt,
        .push_valid,
        .accept,
        .out_pkt,
        .out_valid,
        .almost_full
    );

endmodule

// File: design/inst_buffer.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module inst_buffer
    import frontend_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  fetch_pkt_t [1:0] push_pkt,
    input  logic [1:0]       push_valid,
    input  logic             accept,
    output fetch_pkt_t [1:0] out_pkt,
    output logic [1:0]       out_valid,
    output logic             almost_full
);

    localparam int DEPTH = `IBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_pkt_t       mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [CNT_W-1:0] n_push;
    logic [CNT_W-1:0] n_pop;
    logic [1:0]       pop_valid;

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    // Two oldest entries
    assign out_pkt[0] = mem[head];
    assign out_pkt[1] = mem[head + PTR_W'(1)];

    assign out_valid[0] = (count != '0);
    assign out_valid[1] = (count > CNT_W'(1));

    // Backend takes every valid slot while accept is high
    assign pop_valid = accept ? out_valid : 2'b00;

    //////////////////////////////////////////////////////////////////////
    // Occupancy
    //////////////////////////////////////////////////////////////////////

    // Push pattern is compacted upstream, slot 1 only with slot 0
    assign n_push = flush ? '0 : CNT_W'(push_valid[0]) + CNT_W'(push_valid[1]);
    assign n_pop  = CNT_W'(pop_valid[0]) + CNT_W'(pop_valid[1]);

    assign count_next = flush ? '0 : count + n_push - n_pop;

    // Room for two more pairs still on the way from the cache
    assign almost_full = count_next > CNT_W'(DEPTH - 4);

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!flush) begin
            if (push_valid[0]) begin
                mem[tail] <= push_pkt[0];
            end
            if (push_valid[1]) begin
                mem[tail + PTR_W'(1)] <= push_pkt[1];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(n_pop);
            tail  <= tail + PTR_W'(n_push);
            count <= count_next;
        end
    end

endmodule

// File: design/pc_reg.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module pc_reg
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        flush,
    input  logic [31:0] new_pc,
    input  logic        almost_full,
    output fetch_req_t  fetch_req
);

    fetch_req_t  req_q;
    fetch_req_t  req_d;
    logic [31:0] seq_pc;

    // Pair after an issued request; a held request keeps its pending pc
    always_comb begin
        if (req_q.valid) begin
            seq_pc = {req_q.pc[31:3], 3'b000} + 32'd8;
        end else begin
            seq_pc = req_q.pc;
        end
    end

    // Pc priority is flush, then redirect, then the next pair
    always_comb begin
        if (flush) begin
            req_d.valid = 1'b1;
            req_d.pc    = new_pc;
        end else if (redirect) begin
            // Target waits like any other request while the buffer is nearly full
            req_d.valid = !almost_full;
            req_d.pc    = redirect_pc;
        end else if (almost_full) begin
            req_d.valid = 1'b0;
            req_d.pc    = seq_pc;
        end else begin
            req_d.valid = 1'b1;
            req_d.pc    = seq_pc;
        end
    end

    // Reset leaves RESET_PC pending for the first edge after release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q.valid <= 1'b0;
            req_q.pc    <= `RESET_PC;
        end else begin
            req_q <= req_d;
        end
    end

    assign fetch_req = req_q;

endmodule

// File: src.f
+incdir+design
design/frontend_pkg.sv
design/pc_reg.sv
design/bpu.sv
design/inst_buffer.sv
design/frontend_top.sv
testbench/icache_model.sv
testbench/frontend_tb.sv

// File: testbench/frontend_tb.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module frontend_tb
    import frontend_pkg::*;
();

    logic             clk;
    logic             arst_n;
    logic             accept;
    logic             flush;
    logic [31:0]      new_pc;
    bpu_update_t      update;
    fetch_req_t       fetch_req;
    fetch_rsp_t       fetch_rsp;
    fetch_pkt_t [1:0] out_pkt;
    logic [1:0]       out_valid;

    logic [31:0] vec [0:255];
    fetch_pkt_t  exp_pkt [0:63];
    int          exp_test [0:63];
    int          fl_after [0:7];
    logic [31:0] fl_pc [0:7];
    bpu_update_t fl_upd [0:7];
    int          n_exp = 0;
    int          n_fl = 0;
    int          matched = 0;
    int          errors = 0;
    int          test_err = 0;
    int          cycles = 0;
    int          limit = 100000;
    int          fl_idx = 0;
    logic        flush_due = 1'b0;

    frontend_top dut0 (.*);

    icache_model u_icache (.clk, .arst_n, .fetch_req, .fetch_rsp);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: only %0d of %0d packets arrived", matched, n_exp);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Vector reader and checker
    //////////////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int i;
        $readmemh("testbench/frontend_vectors.txt", vec);
        i = 0;
        while (i < 250 && vec[i] !== 32'd0) begin
            if (vec[i] === 32'd1) begin
                i += 3;
            end else if (vec[i] === 32'd2) begin
                fl_after[n_fl]     = vec[i+1];
                fl_pc[n_fl]        = vec[i+2];
                fl_upd[n_fl].pc    = vec[i+3];
                fl_upd[n_fl].taken = vec[i+4][0];
                n_fl++;
                i += 5;
            end else if (vec[i] === 32'd3) begin
                exp_test[n_exp]            = vec[i+1];
                exp_pkt[n_exp].pc          = vec[i+2];
                exp_pkt[n_exp].inst        = vec[i+3];
                exp_pkt[n_exp].pred_taken  = vec[i+4][0];
                exp_pkt[n_exp].pred_target = vec[i+5];
                n_exp++;
                i += 6;
            end else begin
                $display("vectors file has an unknown record at word %0d", i);
                errors++;
                i = 250;
            end
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            1: return "reset and sequential fetch";
            2: return "unconditional branch";
            3: return "conditional branch, weak counter";
            4: return "flush and training";
            5: return "back-pressure";
            default: return "single-slot fetch";
        endcase
    endfunction

    task automatic check_slot(input fetch_pkt_t got);
        fetch_pkt_t e;
        e = exp_pkt[matched];
        assert (got === e) else begin
            $display("error: out_pkt #%0d got pc=%h inst=%h taken=%h target=%h",
                     matched, got.pc, got.inst, got.pred_taken, got.pred_target);
            $display("       expected pc=%h inst=%h taken=%h target=%h",
                     e.pc, e.inst, e.pred_taken, e.pred_target);
            errors++;
            test_err++;
        end
        matched++;
        if (matched == n_exp || exp_test[matched] != exp_test[matched-1]) begin
            $display("test %0d %s: %s", exp_test[matched-1], test_name(exp_test[matched-1]),
                     test_err == 0 ? "pass" : "fail");
            test_err = 0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Backend driver
    //////////////////////////////////////////////////////////////////////

    initial begin
        arst_n = 1'b0;
        accept = 1'b0;
        flush  = 1'b0;
        new_pc = '0;
        update = '0;
        void'($urandom(32'hb3b6));
        load_vectors();
        if (n_exp == 0) begin
            $display("vectors file holds no expected packets");
            errors++;
        end
        limit = 20 * n_exp + 200;
        // Reset spans five rising edges
        repeat (4) begin
            @(negedge clk);
            assert (out_valid === 2'b00) else begin
                $display("error: out_valid during reset got %h expected 0", out_valid);
                errors++;
                test_err++;
            end
            assert (fetch_req.valid === 1'b0) else begin
                $display("error: fetch_req.valid during reset got %h expected 0",
                         fetch_req.valid);
                errors++;
                test_err++;
            end
        end
        @(posedge clk);
        arst_n <= 1'b1;
        // First request is registered on the edge after release
        @(negedge clk);
        @(negedge clk);
        assert (fetch_req.valid === 1'b1 && fetch_req.pc === `RESET_PC) else begin
            $display("error: fetch_req after reset got valid=%h pc=%h expected valid=1 pc=%h",
                     fetch_req.valid, fetch_req.pc, `RESET_PC);
            errors++;
            test_err++;
        end
        while (matched < n_exp) begin
            // Slots seen here are popped at the coming edge
            @(negedge clk);
            if (accept) begin
                for (int s = 0; s < 2; s++) begin
                    if (out_valid[s] && !flush_due && matched < n_exp) begin
                        check_slot(out_pkt[s]);
                        if (fl_idx < n_fl && matched == fl_after[fl_idx]) begin
                            flush_due = 1'b1;
                        end
                    end
                end
            end
            @(posedge clk);
            if (flush_due) begin
                // Wrong-path slots behind the mispredict were ignored above
                accept <= 1'b0;
                @(posedge clk);
                flush  <= 1'b1;
                new_pc <= fl_pc[fl_idx];
                update <= fl_upd[fl_idx];
                @(posedge clk);
                flush     <= 1'b0;
                fl_idx++;
                flush_due = 1'b0;
            end
            accept <= ($urandom % 100) < 70;
        end
        $display("test 5 %s: %s", test_name(5), errors == 0 ? "pass" : "fail");
        $display("%0d of %0d packets matched, %0d errors", matched, n_exp, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/frontend_vectors.txt
// Tag 1 (M): address word
// Tag 2 (F): packets_before_flush new_pc update_pc update_taken
// Tag 3 (E): test pc inst pred_taken pred_target
1 1c000000 02800401  1 1c000004 02800802  1 1c000008 02800c03
1 1c00000c 02801004  1 1c000010 50003000  1 1c000014 02801405
1 1c000040 02804006  1 1c000044 54003c00  1 1c000080 58002022
1 1c000084 5c001022  1 1c000088 02808807  1 1c00008c 02808c08
1 1c000094 02809409  1 1c000098 0280980a  1 1c000104 0281040c
1 1c000108 0281080d  1 1c00010c 02810c0e
2 09 1c000094 1c000084 1
2 0b 1c000080 1c000084 1
2 0f 1c000104 1c000098 0
3 1 1c000000 02800401 0 1c000004
3 1 1c000004 02800802 0 1c000008
3 1 1c000008 02800c03 0 1c00000c
3 1 1c00000c 02801004 0 1c000010
3 2 1c000010 50003000 1 1c000040
3 2 1c000040 02804006 0 1c000044
3 2 1c000044 54003c00 1 1c000080
3 3 1c000080 58002022 0 1c0000a0
3 3 1c000084 5c001022 0 1c000094
3 4 1c000094 02809409 0 1c000098
3 4 1c000098 0280980a 0 1c00009c
3 4 1c000080 58002022 0 1c0000a0
3 4 1c000084 5c001022 1 1c000094
3 4 1c000094 02809409 0 1c000098
3 4 1c000098 0280980a 0 1c00009c
3 6 1c000104 0281040c 0 1c000108
3 6 1c000108 0281080d 0 1c00010c
3 6 1c00010c 02810c0e 0 1c000110
0

// File: testbench/icache_model.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module icache_model
    import frontend_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp
);

    logic [31:0] imem [0:127];
    logic [31:0] vec [0:255];

    // Opcode field stays zero, so unloaded words are never branches
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'b000000, addr[31:6] ^ addr[25:0]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - `RESET_PC;
        if (offs < 32'd512) begin
            return imem[offs[8:2]];
        end
        return fill_word(addr);
    endfunction

    // Program image from the M records
    initial begin
        int i;
        for (i = 0; i < 128; i++) begin
            imem[i] = fill_word(`RESET_PC + 32'(4 * i));
        end
        $readmemh("testbench/frontend_vectors.txt", vec);
        i = 0;
        while (i < 250 && (vec[i] == 32'd1 || vec[i] == 32'd2 || vec[i] == 32'd3)) begin
            if (vec[i] == 32'd1) begin
                imem[vec[i+1][8:2]] = vec[i+2];
                i += 3;
            end else if (vec[i] == 32'd2) begin
                i += 5;
            end else begin
                i += 6;
            end
        end
    end

    // Fixed one-cycle latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_rsp <= '0;
        end else begin
            fetch_rsp.valid   <= fetch_req.valid;
            fetch_rsp.pc      <= fetch_req.pc;
            fetch_rsp.inst[0] <= read_word({fetch_req.pc[31:3], 3'b000});
            fetch_rsp.inst[1] <= read_word({fetch_req.pc[31:3], 3'b100});
        end
    end

endmodule
